/* verilog/rv32i_pkg.sv */
// Shared encodings for the rv32i_mini core
// Opcodes, branch and ALU operations, access sizes, halt causes, address map
`default_nettype none

package rv32i_pkg;

    // ========================================
    // Instruction encodings
    // ========================================
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;                                 // Same as funct3

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_B = 2'b00,
        MEM_H = 2'b01,
        MEM_W = 2'b10
    } mem_size_e;                               // Low bits of funct3

    typedef enum logic [2:0] {
        HALT_NONE,
        HALT_ECALL,
        HALT_EBREAK,
        HALT_ILLEGAL,
        HALT_MISALIGNED
    } halt_e;

    // ========================================
    // Default address map
    // ========================================
    localparam logic [31:0] DEF_IMEM_WORDS = 32'd1024;
    localparam logic [31:0] DEF_DMEM_BASE  = 32'h0001_0000;
    localparam logic [31:0] DEF_DMEM_WORDS = 32'd1024;
    localparam logic [31:0] DEF_VGA_BASE   = 32'h00FF_0000;
    localparam logic [31:0] DEF_VGA_WORDS  = 32'd9600;      // 38400 bytes of frame buffer

endpackage

`default_nettype wire

/* verilog/rv32i_mem.sv */
// Word-organized memory with byte-lane writes
// Asynchronous read, write at the rising clock edge
`default_nettype none

module rv32i_mem #(
    parameter  int WORDS = 1024,
    localparam int AW    = (WORDS > 1) ? $clog2(WORDS) : 1
) (
    input  wire          clk,
    input  wire          we,
    input  wire [3:0]    be,
    input  wire [AW-1:0] waddr,
    input  wire [31:0]   wdata,
    input  wire [AW-1:0] raddr,
    output logic [31:0]  rdata
);

    logic [31:0] mem [0:WORDS-1];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i])
                    mem[waddr][8*i +: 8] <= wdata[8*i +: 8];   // Byte lane i
            end
        end
    end

    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* verilog/rv32i_decode.sv */
// RV32I instruction decoder
// Splits fields and immediates, maps funct3/funct7 to control, flags illegal words
`default_nettype none

module rv32i_decode (
    input  wire [31:0]           instr,
    output rv32i_pkg::opcode_e   opcode,
    output logic [4:0]           rd,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [31:0]          imm,
    output rv32i_pkg::alu_op_e   alu_op,
    output logic                 alu_src_imm,
    output rv32i_pkg::branch_e   br_op,
    output rv32i_pkg::mem_size_e mem_size,
    output logic                 load_unsigned,
    output logic                 is_ecall,
    output logic                 is_ebreak,
    output logic                 illegal
);
    import rv32i_pkg::*;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // Shared by OP-IMM and OP, alt selects SUB or SRA
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  f3_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign br_op         = branch_e'(funct3);
    assign load_unsigned = funct3[2];                       // LBU, LHU
    assign mem_size      = (funct3[1:0] == 2'b00) ? MEM_B :
                           (funct3[1:0] == 2'b01) ? MEM_H : MEM_W;
    assign is_ecall      = (instr == 32'h0000_0073);
    assign is_ebreak     = (instr == 32'h0010_0073);

    always_comb begin
        imm         = imm_i;
        alu_op      = ALU_ADD;                              // Address adder by default
        alu_src_imm = 1'b1;
        illegal     = 1'b0;
        case (opcode)
            OP_LUI: begin
                imm    = imm_u;
                alu_op = ALU_PASS_B;
            end
            OP_AUIPC:  imm = imm_u;
            OP_JAL:    imm = imm_j;
            OP_JALR:   illegal = (funct3 != 3'b000);
            OP_BRANCH: begin
                imm         = imm_b;
                alu_src_imm = 1'b0;
                illegal     = (funct3[2:1] == 2'b01);       // 010, 011 unused
            end
            OP_LOAD:   illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            OP_STORE: begin
                imm     = imm_s;
                illegal = (funct3 > 3'b010);
            end
            OP_IMM: begin
                alu_op = f3_op(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001)
                    illegal = (funct7 != 7'b0000000);
                else if (funct3 == 3'b101)
                    illegal = ((funct7 & 7'b1011111) != 7'b0000000);
            end
            OP_REG: begin
                alu_src_imm = 1'b0;
                alu_op      = f3_op(funct3, funct7[5]);
                illegal     = (funct7 != 7'b0000000) &&
                              !((funct7 == 7'b0100000) &&
                                ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            OP_FENCE:  illegal = (funct3 != 3'b000);        // FENCE.I not supported
            OP_SYSTEM: illegal = !(is_ecall || is_ebreak);
            default:   illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv32i_regfile.sv */
// Integer register file, 32 x 32 bits
// Two asynchronous reads, one write per clock, x0 reads as zero
`default_nettype none

module rv32i_regfile (
    input  wire        clk,
    input  wire        we,
    input  wire [4:0]  waddr,
    input  wire [31:0] wdata,
    input  wire [4:0]  raddr1,
    input  wire [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [1:31];                   // No storage for x0

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0))
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

/* verilog/rv32i_alu.sv */
// RV32I ALU
// Arithmetic, logic and shift results plus the six branch compares
`default_nettype none

module rv32i_alu (
    input  wire [31:0]          a,
    input  wire [31:0]          b,
    input  rv32i_pkg::alu_op_e  op,
    input  rv32i_pkg::branch_e  br_op,
    output logic [31:0]         result,
    output logic                br_taken
);
    import rv32i_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'd0, lt_s};
            ALU_SLTU:   result = {31'd0, lt_u};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = 32'd0;
        endcase
    end

    // ========================================
    // Branch conditions on rs1 and rs2
    // ========================================
    always_comb begin
        case (br_op)
            BR_EQ:   br_taken = (a == b);
            BR_NE:   br_taken = (a != b);
            BR_LT:   br_taken = lt_s;
            BR_GE:   br_taken = !lt_s;
            BR_LTU:  br_taken = lt_u;
            BR_GEU:  br_taken = !lt_u;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv32i_lsu.sv */
// Load/store unit
// Region decode, alignment check, store lane placement, load extraction
`default_nettype none

module rv32i_lsu #(
    parameter logic [31:0] DMEM_BASE  = 32'h0001_0000,
    parameter int unsigned DMEM_WORDS = 1024,
    parameter logic [31:0] VGA_BASE   = 32'h00FF_0000,
    parameter int unsigned VGA_WORDS  = 9600
) (
    input  wire                   is_load,
    input  wire                   is_store,
    input  wire [31:0]            addr,
    input  rv32i_pkg::mem_size_e  size,
    input  wire                   load_unsigned,
    input  wire [31:0]            store_data,
    input  wire [31:0]            dmem_rdata,
    input  wire [31:0]            vga_rdata,
    output logic [29:0]           word_index,
    output logic                  dmem_we,
    output logic                  vga_we,
    output logic [3:0]            be,
    output logic [31:0]           wdata,
    output logic [31:0]           load_data,
    output logic                  misaligned
);
    import rv32i_pkg::*;

    localparam logic [31:0] DMEM_END = DMEM_BASE + 4 * DMEM_WORDS;
    localparam logic [31:0] VGA_END  = VGA_BASE + 4 * VGA_WORDS;

    logic        in_dmem;
    logic        in_vga;
    logic        bad_align;
    logic [31:0] offset;
    logic [31:0] rword;
    logic [31:0] lane;

    assign in_dmem   = (addr >= DMEM_BASE) && (addr < DMEM_END);
    assign in_vga    = (addr >= VGA_BASE) && (addr < VGA_END);
    assign offset    = addr - (in_vga ? VGA_BASE : DMEM_BASE);
    assign word_index = offset[31:2];

    assign bad_align  = ((size == MEM_H) && addr[0]) ||
                        ((size == MEM_W) && (addr[1:0] != 2'b00));
    assign misaligned = (is_load || is_store) && bad_align;

    assign dmem_we = is_store && in_dmem && !bad_align;
    assign vga_we  = is_store && in_vga && !bad_align;

    // ========================================
    // Store lanes
    // ========================================
    always_comb begin
        case (size)
            MEM_B: begin
                be    = 4'b0001 << addr[1:0];
                wdata = {4{store_data[7:0]}};
            end
            MEM_H: begin
                be    = 4'b0011 << {addr[1], 1'b0};
                wdata = {2{store_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = store_data;
            end
        endcase
    end

    // ========================================
    // Load extraction
    // ========================================
    assign rword = in_vga ? vga_rdata : (in_dmem ? dmem_rdata : 32'd0);   // Unmapped reads zero
    assign lane  = rword >> {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            MEM_B:   load_data = {{24{lane[7] & !load_unsigned}}, lane[7:0]};
            MEM_H:   load_data = {{16{lane[15] & !load_unsigned}}, lane[15:0]};
            default: load_data = rword;
        endcase
    end

    a_one_region: assert final (!(dmem_we && vga_we))
        else $error("Store hit dmem and vga at once");

endmodule

`default_nettype wire

/* verilog/rv32i_core.sv */
// rv32i_mini single-cycle RV32I core
// PC, halt state, next-PC and write-back selection around the datapath blocks
`default_nettype none

module rv32i_core #(
    parameter  int unsigned IMEM_WORDS = rv32i_pkg::DEF_IMEM_WORDS,
    parameter  logic [31:0] DMEM_BASE  = rv32i_pkg::DEF_DMEM_BASE,
    parameter  int unsigned DMEM_WORDS = rv32i_pkg::DEF_DMEM_WORDS,
    parameter  logic [31:0] VGA_BASE   = rv32i_pkg::DEF_VGA_BASE,
    parameter  int unsigned VGA_WORDS  = rv32i_pkg::DEF_VGA_WORDS,
    localparam int          IMEM_AW    = $clog2(IMEM_WORDS)
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               prog_we,
    input  wire [IMEM_AW-1:0] prog_addr,
    input  wire [31:0]        prog_data,
    output logic              retire,
    output logic [31:0]       retire_pc,
    output logic              rd_we,
    output logic [4:0]        rd_addr,
    output logic [31:0]       rd_data,
    output logic              st_en,
    output logic [31:0]       st_addr,
    output logic [3:0]        st_be,
    output logic [31:0]       st_data,
    output logic              halted,
    output rv32i_pkg::halt_e  halt_cause
);
    import rv32i_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_WORDS);
    localparam int VGA_AW  = $clog2(VGA_WORDS);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_imm;
    logic [31:0] pc_next;
    logic [31:0] instr;
    opcode_e     opcode;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        alu_src_imm;
    branch_e     br_op;
    mem_size_e   mem_size;
    logic        load_unsigned;
    logic        is_ecall;
    logic        is_ebreak;
    logic        illegal;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        br_taken;
    logic        is_load;
    logic        is_store;
    logic [29:0] word_index;
    logic        dmem_we;
    logic        vga_we;
    logic [3:0]  mem_be;
    logic [31:0] mem_wdata;
    logic [31:0] load_data;
    logic        misaligned;
    logic [31:0] dmem_rdata;
    logic [31:0] vga_rdata;
    logic        mem_ok;
    logic        halt_now;
    halt_e       cause_now;
    logic        writes_rd;

    // ========================================
    // Datapath blocks
    // ========================================
    rv32i_mem #(.WORDS(IMEM_WORDS)) imem_i (
        .clk(clk), .we(prog_we && rst), .be(4'hF), .waddr(prog_addr),
        .wdata(prog_data), .raddr(pc[IMEM_AW+1:2]), .rdata(instr)
    );

    rv32i_decode decode_i (
        .instr(instr), .opcode(opcode), .rd(rd_addr), .rs1(rs1), .rs2(rs2),
        .imm(imm), .alu_op(alu_op), .alu_src_imm(alu_src_imm), .br_op(br_op),
        .mem_size(mem_size), .load_unsigned(load_unsigned), .is_ecall(is_ecall),
        .is_ebreak(is_ebreak), .illegal(illegal)
    );

    rv32i_regfile regfile_i (
        .clk(clk), .we(rd_we), .waddr(rd_addr), .wdata(rd_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    assign alu_b = alu_src_imm ? imm : rs2_data;    // Branches compare rs1 with rs2

    rv32i_alu alu_i (
        .a(rs1_data), .b(alu_b), .op(alu_op), .br_op(br_op),
        .result(alu_result), .br_taken(br_taken)
    );

    assign is_load  = (opcode == OP_LOAD);
    assign is_store = (opcode == OP_STORE);

    rv32i_lsu #(
        .DMEM_BASE(DMEM_BASE), .DMEM_WORDS(DMEM_WORDS),
        .VGA_BASE(VGA_BASE), .VGA_WORDS(VGA_WORDS)
    ) lsu_i (
        .is_load(is_load), .is_store(is_store), .addr(alu_result), .size(mem_size),
        .load_unsigned(load_unsigned), .store_data(rs2_data),
        .dmem_rdata(dmem_rdata), .vga_rdata(vga_rdata), .word_index(word_index),
        .dmem_we(dmem_we), .vga_we(vga_we), .be(mem_be), .wdata(mem_wdata),
        .load_data(load_data), .misaligned(misaligned)
    );

    assign mem_ok = retire && !illegal;             // Bad encodings never write

    rv32i_mem #(.WORDS(DMEM_WORDS)) dmem_i (
        .clk(clk), .we(dmem_we && mem_ok), .be(mem_be), .waddr(word_index[DMEM_AW-1:0]),
        .wdata(mem_wdata), .raddr(word_index[DMEM_AW-1:0]), .rdata(dmem_rdata)
    );

    rv32i_mem #(.WORDS(VGA_WORDS)) vga_i (
        .clk(clk), .we(vga_we && mem_ok), .be(mem_be), .waddr(word_index[VGA_AW-1:0]),
        .wdata(mem_wdata), .raddr(word_index[VGA_AW-1:0]), .rdata(vga_rdata)
    );

    // ========================================
    // Retire, halt and write-back
    // ========================================
    assign retire    = !rst && !halted;
    assign retire_pc = pc;
    assign pc_plus4  = pc + 32'd4;
    assign pc_imm    = pc + imm;

    assign halt_now  = is_ecall || is_ebreak || illegal || misaligned;
    assign cause_now = is_ecall   ? HALT_ECALL   :
                       is_ebreak  ? HALT_EBREAK  :
                       illegal    ? HALT_ILLEGAL :
                       misaligned ? HALT_MISALIGNED : HALT_NONE;

    assign writes_rd = (opcode == OP_LUI) || (opcode == OP_AUIPC) || (opcode == OP_JAL) ||
                       (opcode == OP_JALR) || is_load || (opcode == OP_IMM) ||
                       (opcode == OP_REG);
    assign rd_we     = retire && writes_rd && !halt_now && (rd_addr != 5'd0);

    always_comb begin
        case (opcode)
            OP_AUIPC:         rd_data = pc_imm;
            OP_JAL, OP_JALR:  rd_data = pc_plus4;    // Link value
            OP_LOAD:          rd_data = load_data;
            default:          rd_data = alu_result;  // LUI passes the U-immediate
        endcase
    end

    always_comb begin
        case (opcode)
            OP_JAL:    pc_next = pc_imm;
            OP_JALR:   pc_next = {alu_result[31:1], 1'b0};
            OP_BRANCH: pc_next = br_taken ? pc_imm : pc_plus4;
            default:   pc_next = pc_plus4;
        endcase
    end

    assign st_en   = retire && is_store && !illegal && !misaligned;
    assign st_addr = {alu_result[31:2], 2'b00};
    assign st_be   = mem_be;
    assign st_data = mem_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= 32'd0;
            halted     <= 1'b0;
            halt_cause <= HALT_NONE;
        end else if (retire) begin
            if (halt_now) begin
                halted     <= 1'b1;                  // PC stays on the halting instruction
                halt_cause <= cause_now;
            end else begin
                pc <= pc_next;
            end
        end
    end

    a_prog_in_reset: assert property (@(posedge clk) prog_we |-> rst)
        else $error("Program write outside reset");
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        retire |-> (retire_pc[1:0] == 2'b00))
        else $error("Retired PC not word aligned");
    a_pc_frozen: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else $error("PC moved while halted");

endmodule

`default_nettype wire

/* tb/rv32i_core_tb.sv */
// Testbench for the rv32i_mini core
// Loads each program from the cases file, runs it and checks retire, store and halt traffic
`default_nettype none

module rv32i_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int SETTLE     = CLK_PERIOD / 4;    // Sample point after the falling edge

    logic        clk;
    logic        rst;
    logic        prog_we;
    logic [9:0]  prog_addr;
    logic [31:0] prog_data;
    logic        retire;
    logic [31:0] retire_pc;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        st_en;
    logic [31:0] st_addr;
    logic [3:0]  st_be;
    logic [31:0] st_data;
    logic        halted;
    halt_e       halt_cause;

    string       lines[$];
    logic [31:0] prog[$];
    logic [31:0] exp_pc[$];
    int          exp_rd[$];                        // -1 when no register write
    logic [31:0] exp_rdv[$];
    bit          exp_st[$];
    logic [31:0] exp_sa[$];
    logic [3:0]  exp_sbe[$];
    logic [31:0] exp_sd[$];
    string       exp_halt;
    string       tname;
    int          total_r;
    int          total_t;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    rv32i_core dut_i (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .retire(retire), .retire_pc(retire_pc),
        .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data), .st_en(st_en),
        .st_addr(st_addr), .st_be(st_be), .st_data(st_data), .halted(halted),
        .halt_cause(halt_cause)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_value(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_other(input string msg);
        $display("Test %s: %s", tname, msg);
        errors++;
        test_errors++;
    endtask

    // ========================================
    // Cases file parsing
    // ========================================
    task automatic read_cases();
        int    fd;
        string line;
        string tag;
        fd = $fopen("tb/rv32i_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file tb/rv32i_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%s", tag) == 1 && tag.substr(0, 0) != "#") begin
                    lines.push_back(line);
                    if (tag == "R") total_r++;
                    if (tag == "T") total_t++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Collects one test starting at a T line, leaves idx on the next T line
    task automatic load_test(inout int idx);
        string       tag;
        string       tok;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        prog.delete();
        exp_pc.delete();
        exp_rd.delete();
        exp_rdv.delete();
        exp_st.delete();
        exp_sa.delete();
        exp_sbe.delete();
        exp_sd.delete();
        exp_halt = "HALT_NONE";
        void'($sscanf(lines[idx], "%s %s", tag, tname));
        idx++;
        while (idx < lines.size()) begin
            void'($sscanf(lines[idx], "%s", tag));
            if (tag == "T")
                break;
            if (tag == "P") begin
                void'($sscanf(lines[idx], "%s %h", tag, a));
                prog.push_back(a);
            end else if (tag == "R") begin
                c = 32'd0;
                void'($sscanf(lines[idx], "%s %h %s %h", tag, a, tok, c));
                exp_pc.push_back(a);
                exp_rd.push_back((tok == "none") ? -1 : tok.atoi());
                exp_rdv.push_back(c);
                exp_st.push_back(1'b0);
                exp_sa.push_back(32'd0);
                exp_sbe.push_back(4'd0);
                exp_sd.push_back(32'd0);
            end else if (tag == "S") begin
                void'($sscanf(lines[idx], "%s %h %h %h", tag, a, b, c));
                exp_st[exp_st.size() - 1]   = 1'b1;     // Belongs to the last retire
                exp_sa[exp_sa.size() - 1]   = a;
                exp_sbe[exp_sbe.size() - 1] = b[3:0];
                exp_sd[exp_sd.size() - 1]   = c;
            end else if (tag == "H") begin
                void'($sscanf(lines[idx], "%s %s", tag, exp_halt));
            end
            idx++;
        end
    endtask

    // ========================================
    // Checks on one retired instruction
    // ========================================
    task automatic check_retire(input int ri);
        if (ri >= exp_pc.size()) begin
            assert (0) else report_other($sformatf("more retires than expected, pc %h",
                                                   retire_pc));
        end else begin
            assert (retire_pc === exp_pc[ri])
                else report_value($sformatf("retire_pc %h, expected %h", retire_pc, exp_pc[ri]));
            if (exp_rd[ri] < 0) begin
                assert (rd_we === 1'b0)
                    else report_value($sformatf("pc %h rd_we high, expected no write", retire_pc));
            end else begin
                assert (rd_we === 1'b1 && rd_addr === exp_rd[ri] && rd_data === exp_rdv[ri])
                    else report_value($sformatf("pc %h write x%0d=%h we %b, expected x%0d=%h",
                        retire_pc, rd_addr, rd_data, rd_we, exp_rd[ri], exp_rdv[ri]));
            end
            if (exp_st[ri]) begin
                assert (st_en === 1'b1 && st_addr === exp_sa[ri] && st_be === exp_sbe[ri] &&
                        st_data === exp_sd[ri])
                    else report_value($sformatf("pc %h store %b %h %h %h, expected %h %h %h",
                        retire_pc, st_en, st_addr, st_be, st_data,
                        exp_sa[ri], exp_sbe[ri], exp_sd[ri]));
            end else begin
                assert (st_en === 1'b0)
                    else report_value($sformatf("pc %h unexpected store", retire_pc));
            end
        end
    endtask

    task automatic run_test();
        int gap;
        int ri;
        test_errors = 0;
        gap = 4 + ($urandom % 5);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            prog_we   = 1'b1;
            prog_addr = i[9:0];
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (gap) @(negedge clk);
        rst = 1'b0;
        ri  = 0;
        forever begin
            #SETTLE;
            if (halted === 1'b1)
                break;
            if (retire === 1'b1) begin
                check_retire(ri);
                ri++;
            end
            @(negedge clk);
        end
        assert (ri >= exp_pc.size())
            else report_other($sformatf("halted after %0d retires, expected %0d",
                                        ri, exp_pc.size()));
        assert (halt_cause.name() == exp_halt)
            else report_value($sformatf("halt_cause %s, expected %s",
                                        halt_cause.name(), exp_halt));
        repeat (2) begin
            assert (retire === 1'b0 && rd_we === 1'b0 && st_en === 1'b0)
                else report_other("core kept retiring after the halt");
            @(negedge clk);
            #SETTLE;
        end
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("Test %s: %s", tname, (test_errors == 0) ? "passed" : "failed");
    endtask

    initial begin
        int idx;
        clk_init: begin
            rst       = 1'b1;
            prog_we   = 1'b0;
            prog_addr = 10'd0;
            prog_data = 32'd0;
        end
        void'($urandom(81853));
        read_cases();
        // Budget is the retire count plus a margin per test, doubled
        fork
            begin
                #((total_r + 10 * total_t) * CLK_PERIOD * 2);
                $display("Timeout: the tests ran longer than their expected length");
                $display("Finished with errors");
                $finish;
            end
        join_none
        idx = 0;
        while (idx < lines.size()) begin
            load_test(idx);
            run_test();
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* rv32i_mini.f */
verilog/rv32i_pkg.sv
verilog/rv32i_mem.sv
verilog/rv32i_decode.sv
verilog/rv32i_regfile.sv
verilog/rv32i_alu.sv
verilog/rv32i_lsu.sv
verilog/rv32i_core.sv
tb/rv32i_core_tb.sv

/* tb/rv32i_cases.txt */
# T name | P instruction word | R retire_pc rd data, or R retire_pc none
# S st_addr st_be st_data (store of the previous R) | H expected halt_cause
T alu_ops
P ffb00093
P 00300113
P 0020a1b3
P 0020b233
P 401102b3
P 4010d313
P 01c0d393
P fff0c413
P 123454b7
P 00211533
P 0024e5b3
P 0020f633
P 0010a693
P 0010b713
P 00000073
R 00000000 1 fffffffb
R 00000004 2 00000003
R 00000008 3 00000001
R 0000000c 4 00000000
R 00000010 5 00000008
R 00000014 6 fffffffd
R 00000018 7 0000000f
R 0000001c 8 00000004
R 00000020 9 12345000
R 00000024 10 00000018
R 00000028 11 12345003
R 0000002c 12 00000003
R 00000030 13 00000001
R 00000034 14 00000000
R 00000038 none
H HALT_ECALL
T control_flow
P 00100093
P 00008463
P 00009463
P 06300113
P 00104463
P 06300113
P 0000e463
P 00105463
P 0000f463
P 06300113
P 008002ef
P 06300113
P 00000317
P 00c303e7
P 06300113
P 00100073
R 00000000 1 00000001
R 00000004 none
R 00000008 none
R 00000010 none
R 00000018 none
R 0000001c none
R 00000020 none
R 00000028 5 0000002c
R 00000030 6 00000030
R 00000034 7 00000038
R 0000003c none
H HALT_EBREAK
T data_memory
P 000100b7
P f8000113
P 0020a023
P 7a500193
P 003080a3
P 00309323
P 00108203
P 0010c283
P 00009303
P 0060d383
P 0000a403
P 0020a483
R 00000000 1 00010000
R 00000004 2 ffffff80
R 00000008 none
S 00010000 f ffffff80
R 0000000c 3 000007a5
R 00000010 none
S 00010000 2 a5a5a5a5
R 00000014 none
S 00010004 c 07a507a5
R 00000018 4 ffffffa5
R 0000001c 5 000000a5
R 00000020 6 ffffa580
R 00000024 7 000007a5
R 00000028 8 ffffa580
R 0000002c none
H HALT_MISALIGNED
T vga_region
P 00ff00b7
P 12300113
P 0020a223
P 0040a183
P 00202023
P 00002203
P ffffffff
R 00000000 1 00ff0000
R 00000004 2 00000123
R 00000008 none
S 00ff0004 f 00000123
R 0000000c 3 00000123
R 00000010 none
S 00000000 f 00000123
R 00000014 4 00000000
R 00000018 none
H HALT_ILLEGAL
T x0_writes
P 00500013
P 000000b3
P 00000073
R 00000000 none
R 00000004 1 00000000
R 00000008 none
H HALT_ECALL
